// File: filelist.f
+incdir+rtl
rtl/sr_dft_pkg.sv
rtl/sr_data_pkg.sv
rtl/dft_ctrl_if.sv
rtl/clk_gate_latch.sv
rtl/srclk_ctl.sv
rtl/dft_clock_controller.sv
rtl/sr_shift_chain.sv
rtl/sr_adapt_top.sv
tb/tb_sr_adapt.sv

// File: Bender.yml
package:
  name: sr_adapt

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sr_dft_pkg.sv
      - rtl/sr_data_pkg.sv
      - rtl/dft_ctrl_if.sv
      - rtl/clk_gate_latch.sv
      - rtl/srclk_ctl.sv
      - rtl/dft_clock_controller.sv
      - rtl/sr_shift_chain.sv
      - rtl/sr_adapt_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_sr_adapt.sv

// File: tb/tb_sr_adapt.sv
////////////////////////////////////////////////////////////
// Serial adapter testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sr_adapt_params.svh"

module tb_sr_adapt
    import sr_data_pkg::*;
;
    typedef struct packed {
        logic        mode_n;
        logic        shift_n;
        logic        fastclkn;
        logic        scg_en;
        logic        occ_en;
        logic        sel_n;
        logic [15:0] cycles;     // Even so that every row starts with the clocks low
        logic [15:0] exp_gated;
        logic [15:0] exp_reset;
    } row_t;

    localparam int ROWS = 9;

    logic arst_n, clk, fab_rx, fab_tx, shift_clk, scg_en, fastclkn;
    logic mode_n, shift_n, sel_n, occ_en, sr_rx_data, sr_tx_data;
    logic aib_tx_out, rst_rx_clk, rst_tx_clk, g_rx_clk, g_tx_clk;
    sr_word_t tx_word, rx_word, exp_rx, tx_cur;
    row_t        rows [ROWS];
    logic [15:0] lfsr;
    int cnt_g_rx, cnt_g_tx, cnt_r_rx, cnt_r_tx, rx_mcnt, tx_mcnt;
    int cycle_cnt, cycle_limit;
    logic tx_fresh, func_row;

    sr_adapt_top sr_adapt_top_i (
        .arst_n(arst_n), .aib_fabric_rx_sr_clk_in(fab_rx), .aib_fabric_tx_sr_clk_in(fab_tx),
        .r_sr_osc_clk_scg_en(scg_en), .dft_adpt_aibiobsr_fastclkn(fastclkn),
        .adapter_scan_mode_n(mode_n), .adapter_scan_shift_n(shift_n),
        .adapter_scan_shift_clk(shift_clk), .adapter_scan_user_clk3(clk),
        .adapter_clk_sel_n(sel_n), .adapter_occ_enable(occ_en), .sr_rx_data(sr_rx_data),
        .tx_word(tx_word), .aib_fabric_tx_sr_clk_out(aib_tx_out),
        .sr_clock_reset_rx_osc_clk(rst_rx_clk), .sr_clock_reset_tx_osc_clk(rst_tx_clk),
        .sr_clock_rx_osc_clk(g_rx_clk), .sr_clock_tx_osc_clk(g_tx_clk),
        .rx_word(rx_word), .sr_tx_data(sr_tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic report_mismatch(input string name, input int exp_v, input int got_v);
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic set_row(input int i, input logic [5:0] pins, input int cyc,
                           input int eg, input int er);
        rows[i] = {pins, 16'(cyc), 16'(eg), 16'(er)};
    endtask

    // One user_clk period with every input driven on the falling edge
    task automatic tick();
        @(negedge clk);
        fab_rx    = ~fab_rx;
        fab_tx    = ~fab_tx;
        shift_clk = ~shift_clk;
        if (!fab_rx) begin
            sr_rx_data = lfsr[0];       // One new bit per serial period
            lfsr       = lfsr_next(lfsr);
        end
        if (tx_mcnt >= 4 && !tx_fresh) begin
            tx_word  = tx_word + 8'h3b;  // Mid-word and away from the reload edge
            tx_fresh = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Edge counters and serial model
    ////////////////////////////////////////////////////////////

    always @(posedge g_rx_clk) cnt_g_rx++;
    always @(posedge g_tx_clk) cnt_g_tx++;
    always @(posedge rst_rx_clk) cnt_r_rx++;
    always @(posedge rst_tx_clk) cnt_r_tx++;

    always @(posedge g_rx_clk) begin
        if (arst_n) begin
            exp_rx = {exp_rx[`SR_WORD_W-2:0], sr_rx_data};  // MSB first
            rx_mcnt++;
            if (rx_mcnt == `SR_WORD_W) begin
                rx_mcnt = 0;
                #1;
                assert (rx_word == exp_rx) else report_mismatch("rx_word", exp_rx, rx_word);
            end
        end
    end

    always @(negedge g_tx_clk) begin
        if (arst_n) begin
            if (tx_mcnt == 0) begin
                tx_cur   = tx_word;
                tx_fresh = 1'b0;
            end
            tx_mcnt = (tx_mcnt + 1) % `SR_WORD_W;
            #1;
            assert (sr_tx_data == tx_cur[(`SR_WORD_W - tx_mcnt) % `SR_WORD_W])
                else report_mismatch("sr_tx_data",
                                     tx_cur[(`SR_WORD_W - tx_mcnt) % `SR_WORD_W], sr_tx_data);
        end
    end

    // Fabric tx clock passes straight out in functional mode
    always @(posedge clk) begin
        if (arst_n && func_row) begin
            assert (aib_tx_out == fab_tx)
                else report_mismatch("aib_fabric_tx_sr_clk_out", fab_tx, aib_tx_out);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    initial begin
        // Pin order is mode_n shift_n fastclkn scg_en occ_en sel_n
        set_row(0, 6'b111001, 40, 20, 20);  // Functional with gating off
        set_row(1, 6'b111101, 16, 0, 8);    // Gating on
        set_row(2, 6'b110100, 16, 8, 8);    // fastclkn bypass
        set_row(3, 6'b111001, 24, 12, 12);
        set_row(4, 6'b001111, 32, 16, 16);  // Scan shift
        set_row(5, 6'b011111, 16, `SR_OCC_PULSES, `SR_OCC_PULSES);  // Capture
        set_row(6, 6'b001111, 16, 8, 8);
        set_row(7, 6'b011111, 16, `SR_OCC_PULSES, `SR_OCC_PULSES);
        set_row(8, 6'b111001, 24, 12, 12);
        cycle_limit = 4 + 50;
        for (int i = 0; i < ROWS; i++) cycle_limit += rows[i].cycles;
        cycle_cnt = 0;
        arst_n = 1'b0;
        {fab_rx, fab_tx, shift_clk, sr_rx_data} = '0;
        {mode_n, shift_n, fastclkn, scg_en, occ_en, sel_n} = rows[0][$bits(row_t)-1 -: 6];
        tx_word = 8'hA5;
        tx_fresh = 1'b1;
        lfsr = 16'd48397;
        exp_rx = '0;
        func_row = 1'b0;
        {rx_mcnt, tx_mcnt} = '0;
        repeat (4) tick();
        arst_n = 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            {mode_n, shift_n, fastclkn, scg_en, occ_en, sel_n} = rows[i][$bits(row_t)-1 -: 6];
            func_row = fastclkn & mode_n;
            {cnt_g_rx, cnt_g_tx, cnt_r_rx, cnt_r_tx} = '0;
            repeat (rows[i].cycles) tick();
            assert (cnt_g_rx == rows[i].exp_gated)
                else report_mismatch("sr_clock_rx_osc_clk edges", rows[i].exp_gated, cnt_g_rx);
            assert (cnt_g_tx == rows[i].exp_gated)
                else report_mismatch("sr_clock_tx_osc_clk edges", rows[i].exp_gated, cnt_g_tx);
            assert (cnt_r_rx == rows[i].exp_reset)
                else report_mismatch("sr_clock_reset_rx_osc_clk edges",
                                     rows[i].exp_reset, cnt_r_rx);
            assert (cnt_r_tx == rows[i].exp_reset)
                else report_mismatch("sr_clock_reset_tx_osc_clk edges",
                                     rows[i].exp_reset, cnt_r_tx);
        end
        // Last tx bit is checked just after its falling edge
        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: rtl/sr_adapt_top.sv
////////////////////////////////////////////////////////////
// Serial adapter top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sr_adapt_top
    import sr_data_pkg::*;
(
    input  logic     arst_n,
    input  logic     aib_fabric_rx_sr_clk_in,
    input  logic     aib_fabric_tx_sr_clk_in,
    input  logic     r_sr_osc_clk_scg_en,
    input  logic     dft_adpt_aibiobsr_fastclkn,
    input  logic     adapter_scan_mode_n,
    input  logic     adapter_scan_shift_n,
    input  logic     adapter_scan_shift_clk,
    input  logic     adapter_scan_user_clk3,
    input  logic     adapter_clk_sel_n,
    input  logic     adapter_occ_enable,
    input  logic     sr_rx_data,
    input  sr_word_t tx_word,
    output logic     aib_fabric_tx_sr_clk_out,
    output logic     sr_clock_reset_rx_osc_clk,
    output logic     sr_clock_reset_tx_osc_clk,
    output logic     sr_clock_rx_osc_clk,
    output logic     sr_clock_tx_osc_clk,
    output sr_word_t rx_word,
    output logic     sr_tx_data
);

    logic occ_rx_clk;
    logic occ_tx_clk;
    logic rx_mux_clk;
    logic tx_mux_clk;
    logic osc_clk_en;

    dft_ctrl_if dft_bus ();

    srclk_ctl srclk_ctl_i (
        .aib_fabric_rx_sr_clk_in    (aib_fabric_rx_sr_clk_in),
        .aib_fabric_tx_sr_clk_in    (aib_fabric_tx_sr_clk_in),
        .r_sr_osc_clk_scg_en        (r_sr_osc_clk_scg_en),
        .dft_adpt_aibiobsr_fastclkn (dft_adpt_aibiobsr_fastclkn),
        .adapter_scan_mode_n        (adapter_scan_mode_n),
        .adapter_scan_shift_n       (adapter_scan_shift_n),
        .adapter_scan_shift_clk     (adapter_scan_shift_clk),
        .adapter_scan_user_clk3     (adapter_scan_user_clk3),
        .adapter_clk_sel_n          (adapter_clk_sel_n),
        .adapter_occ_enable         (adapter_occ_enable),
        .occ_rx_clk                 (occ_rx_clk),
        .occ_tx_clk                 (occ_tx_clk),
        .dft                        (dft_bus.ctl),
        .rx_mux_clk                 (rx_mux_clk),
        .tx_mux_clk                 (tx_mux_clk),
        .osc_clk_en                 (osc_clk_en)
    );

    // One OCC per direction
    dft_clock_controller occ_rx_i (
        .arst_n  (arst_n),
        .dft     (dft_bus.occ),
        .out_clk (occ_rx_clk)
    );

    dft_clock_controller occ_tx_i (
        .arst_n  (arst_n),
        .dft     (dft_bus.occ),
        .out_clk (occ_tx_clk)
    );

    // Ungated copies for reset logic and the fabric
    assign sr_clock_reset_rx_osc_clk = rx_mux_clk;
    assign sr_clock_reset_tx_osc_clk = tx_mux_clk;
    assign aib_fabric_tx_sr_clk_out  = tx_mux_clk;

    clk_gate_latch rx_scg_i (
        .clk  (rx_mux_clk),
        .en   (osc_clk_en),
        .gclk (sr_clock_rx_osc_clk)
    );

    clk_gate_latch tx_scg_i (
        .clk  (tx_mux_clk),
        .en   (osc_clk_en),
        .gclk (sr_clock_tx_osc_clk)
    );

    sr_shift_chain sr_shift_chain_i (
        .arst_n     (arst_n),
        .rx_clk     (sr_clock_rx_osc_clk),
        .tx_clk     (sr_clock_tx_osc_clk),
        .sr_rx_data (sr_rx_data),
        .tx_word    (tx_word),
        .rx_word    (rx_word),
        .sr_tx_data (sr_tx_data)
    );

endmodule

// File: rtl/sr_shift_chain.sv
////////////////////////////////////////////////////////////
// Serial shift chain
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sr_adapt_params.svh"

module sr_shift_chain
    import sr_data_pkg::*;
(
    input  logic     arst_n,
    input  logic     rx_clk,      // Gated rx serial clock
    input  logic     tx_clk,      // Gated tx serial clock
    input  logic     sr_rx_data,
    input  sr_word_t tx_word,
    output sr_word_t rx_word,
    output logic     sr_tx_data
);

    localparam sr_cnt_t CNT_LAST = sr_cnt_t'(`SR_WORD_W - 1);

    sr_word_t rx_sr;
    sr_cnt_t  rx_cnt;
    sr_word_t tx_sr;
    sr_cnt_t  tx_cnt;

    ////////////////////////////////////////////////////////////
    // Rx deserializer
    ////////////////////////////////////////////////////////////

    // MSB arrives first
    always_ff @(posedge rx_clk) begin
        rx_sr <= {rx_sr[`SR_WORD_W-2:0], sr_rx_data};
    end

    always_ff @(posedge rx_clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_cnt  <= '0;
            rx_word <= '0;
        end else begin
            if (rx_cnt == CNT_LAST) begin
                rx_cnt  <= '0;
                rx_word <= {rx_sr[`SR_WORD_W-2:0], sr_rx_data};  // Include the last bit
            end else begin
                rx_cnt <= rx_cnt + sr_cnt_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Tx serializer
    ////////////////////////////////////////////////////////////

    // Load at count zero, then shift left on each falling edge
    always_ff @(negedge tx_clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_cnt <= '0;
            tx_sr  <= '0;
        end else begin
            if (tx_cnt == '0) begin
                tx_sr <= tx_word;
            end else begin
                tx_sr <= {tx_sr[`SR_WORD_W-2:0], 1'b0};
            end
            tx_cnt <= (tx_cnt == CNT_LAST) ? '0 : tx_cnt + sr_cnt_t'(1);
        end
    end

    assign sr_tx_data = tx_sr[`SR_WORD_W-1];

endmodule

// File: rtl/dft_clock_controller.sv
////////////////////////////////////////////////////////////
// On-chip clock controller
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "sr_adapt_params.svh"

module dft_clock_controller
    import sr_dft_pkg::*;
(
    input  logic       arst_n,
    dft_ctrl_if.occ    dft,
    output logic       out_clk
);

    localparam occ_cnt_t PULSE_NUM = occ_cnt_t'(`SR_OCC_PULSES);

    logic       scan_en_q;      // scan_enable in the user_clk domain
    logic       occ_active;
    logic       burst_en;
    logic       burst_clk;
    occ_state_t state;
    occ_state_t state_nxt;
    occ_cnt_t   pulse_cnt;
    occ_cnt_t   pulse_cnt_nxt;

    assign occ_active = dft.atpg_mode & dft.occ_enable;

    always_ff @(posedge dft.user_clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_en_q <= 1'b0;
            state     <= OCC_IDLE;
            pulse_cnt <= '0;
        end else begin
            scan_en_q <= dft.scan_enable;
            state     <= state_nxt;
            pulse_cnt <= pulse_cnt_nxt;
        end
    end

    ////////////////////////////////////////////////////////////
    // Burst sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt     = state;
        pulse_cnt_nxt = pulse_cnt;
        case (state)
            OCC_IDLE: begin
                if (scan_en_q) begin
                    state_nxt = OCC_SHIFT;
                end
            end
            OCC_SHIFT: begin
                if (!scan_en_q) begin
                    state_nxt = OCC_ARM;
                end
            end
            OCC_ARM: begin
                state_nxt     = OCC_PULSE;
                pulse_cnt_nxt = occ_cnt_t'(1);  // First pulse leaves on this edge
            end
            OCC_PULSE: begin
                if (pulse_cnt == PULSE_NUM) begin
                    state_nxt = OCC_DONE;
                end else begin
                    pulse_cnt_nxt = pulse_cnt + occ_cnt_t'(1);
                end
            end
            OCC_DONE: begin
                if (scan_en_q) begin
                    state_nxt = OCC_SHIFT;  // Next load starts
                end
            end
            default: state_nxt = OCC_IDLE;
        endcase

        // Leaving ATPG or disabling the OCC aborts any burst
        if (!occ_active) begin
            state_nxt     = OCC_IDLE;
            pulse_cnt_nxt = '0;
        end
    end

    // Gate opens from ARM until the last pulse is out
    assign burst_en = (state == OCC_ARM) ||
                      ((state == OCC_PULSE) && (pulse_cnt != PULSE_NUM));

    clk_gate_latch burst_gate_i (
        .clk  (dft.user_clk),
        .en   (burst_en),
        .gclk (burst_clk)
    );

    // Output select
    always_comb begin
        if (!dft.atpg_mode) begin
            out_clk = dft.clk_sel_n ? dft.user_clk : dft.test_clk;
        end else if (dft.scan_enable) begin
            out_clk = dft.test_clk;   // Shift
        end else begin
            out_clk = burst_clk;      // Capture
        end
    end

endmodule

// File: rtl/srclk_ctl.sv
////////////////////////////////////////////////////////////
// Serial clock control
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module srclk_ctl (
    input  logic       aib_fabric_rx_sr_clk_in,
    input  logic       aib_fabric_tx_sr_clk_in,
    input  logic       r_sr_osc_clk_scg_en,         // Static clock gating request
    input  logic       dft_adpt_aibiobsr_fastclkn,
    input  logic       adapter_scan_mode_n,
    input  logic       adapter_scan_shift_n,
    input  logic       adapter_scan_shift_clk,
    input  logic       adapter_scan_user_clk3,      // Fast capture clock
    input  logic       adapter_clk_sel_n,
    input  logic       adapter_occ_enable,
    input  logic       occ_rx_clk,
    input  logic       occ_tx_clk,
    dft_ctrl_if.ctl    dft,
    output logic       rx_mux_clk,
    output logic       tx_mux_clk,
    output logic       osc_clk_en
);

    logic scan_mode;
    logic scg_bypass;
    logic mux_sel_n;

    ////////////////////////////////////////////////////////////
    // DFT pin decode
    ////////////////////////////////////////////////////////////

    assign scan_mode = ~adapter_scan_mode_n;

    // Gating is overridden in scan or when the fast clock pin is low
    assign scg_bypass = ~dft_adpt_aibiobsr_fastclkn | scan_mode;

    // Fabric clocks only in true functional mode
    assign mux_sel_n = dft_adpt_aibiobsr_fastclkn & ~scan_mode;

    assign osc_clk_en = scg_bypass | ~r_sr_osc_clk_scg_en;

    ////////////////////////////////////////////////////////////
    // Scan bundle to the OCCs
    ////////////////////////////////////////////////////////////

    assign dft.user_clk    = adapter_scan_user_clk3;
    assign dft.test_clk    = adapter_scan_shift_clk;
    assign dft.clk_sel_n   = adapter_clk_sel_n;
    assign dft.scan_enable = ~adapter_scan_shift_n;  // Pin is active low
    assign dft.occ_enable  = adapter_occ_enable;
    assign dft.atpg_mode   = scan_mode;

    ////////////////////////////////////////////////////////////
    // Clock muxing
    ////////////////////////////////////////////////////////////

    // Rx oscillator clock
    assign rx_mux_clk = mux_sel_n ? aib_fabric_rx_sr_clk_in : occ_rx_clk;

    // Tx oscillator clock
    assign tx_mux_clk = mux_sel_n ? aib_fabric_tx_sr_clk_in : occ_tx_clk;

endmodule

// File: rtl/clk_gate_latch.sv
////////////////////////////////////////////////////////////
// Latch clock gate
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clk_gate_latch (
    input  logic clk,
    input  logic en,
    output logic gclk
);

    logic en_lat;

    // Enable only moves while clk is low, so gclk cannot be chopped
    always_latch begin
        if (!clk) begin
            en_lat <= en;
        end
    end

    assign gclk = clk & en_lat;

endmodule

// File: rtl/dft_ctrl_if.sv
////////////////////////////////////////////////////////////
// Scan control bundle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface dft_ctrl_if;

    logic user_clk;     // Fast clock for capture pulses
    logic test_clk;     // Scan shift clock
    logic clk_sel_n;    // High picks user_clk outside ATPG
    logic scan_enable;  // Active high inside the design
    logic occ_enable;
    logic atpg_mode;

    modport ctl (
        output user_clk,
        output test_clk,
        output clk_sel_n,
        output scan_enable,
        output occ_enable,
        output atpg_mode
    );

    modport occ (
        input user_clk,
        input test_clk,
        input clk_sel_n,
        input scan_enable,
        input occ_enable,
        input atpg_mode
    );

endinterface

// File: rtl/sr_data_pkg.sv
////////////////////////////////////////////////////////////
// Shift chain data types
////////////////////////////////////////////////////////////

`include "sr_adapt_params.svh"

package sr_data_pkg;

    // One serial word
    typedef logic [`SR_WORD_W-1:0] sr_word_t;

    // Bit position within a word
    typedef logic [$clog2(`SR_WORD_W)-1:0] sr_cnt_t;

endpackage

// File: rtl/sr_dft_pkg.sv
////////////////////////////////////////////////////////////
// DFT clocking types
////////////////////////////////////////////////////////////

package sr_dft_pkg;

    // Capture pulse counter
    typedef logic [1:0] occ_cnt_t;

    // OCC sequencing, one state per scan phase
    typedef enum logic [2:0] {
        OCC_IDLE,   // Functional or OCC disabled
        OCC_SHIFT,  // Shift clock passed through
        OCC_ARM,    // Shift ended, first pulse follows
        OCC_PULSE,  // Burst in progress
        OCC_DONE    // Burst complete, output parked low
    } occ_state_t;

endpackage

// File: rtl/sr_adapt_params.svh
////////////////////////////////////////////////////////////
// Serial adapter parameters
////////////////////////////////////////////////////////////

`ifndef SR_ADAPT_PARAMS_SVH
`define SR_ADAPT_PARAMS_SVH

// Bits per serial word, shared by the rx and tx halves
`define SR_WORD_W 8

// Capture pulses per OCC burst
// Must fit in the 2-bit pulse counter, so at most 3
`define SR_OCC_PULSES 2

`endif
